/* xt_pkg.sv */
/*
 * Shared types and constants for the XT keyboard and speaker block.
 * Single clock domain, I/O window 0x000-0x0FF only, 8-bit data.
 */
package xt_pkg;

    localparam int IO_ADDR_W = 10;
    localparam int DATA_W    = 8;

    typedef logic [DATA_W-1:0]    byte_t;
    typedef logic [IO_ADDR_W-1:0] io_addr_t;
    typedef logic [15:0]          tmr_count_t;

    // Block numbers from address bits 7..5
    localparam logic [2:0] BLK_DMA      = 3'd0;
    localparam logic [2:0] BLK_TIMER    = 3'd2;
    localparam logic [2:0] BLK_PPI      = 3'd3;
    localparam logic [2:0] BLK_DMA_PAGE = 3'd4;

    localparam io_addr_t PORT_TMR2     = 10'h042;
    localparam io_addr_t PORT_TMR_CTRL = 10'h043;
    localparam io_addr_t PORT_A        = 10'h060;
    localparam io_addr_t PORT_B        = 10'h061;
    localparam io_addr_t PORT_C        = 10'h062;

    // Counter select field of the 8253 control word
    localparam logic [1:0] TMR_SC_CTR2 = 2'b10;

    localparam int PS2_IDLE_CYCLES = 1000;
    localparam int PS2_FRAME_BITS  = 11;
    localparam int PS2_IDLE_W      = $clog2(PS2_IDLE_CYCLES);
    localparam int PS2_BIT_CNT_W   = $clog2(PS2_FRAME_BITS + 1);

    typedef logic [PS2_IDLE_W-1:0]    ps2_idle_cnt_t;
    typedef logic [PS2_BIT_CNT_W-1:0] ps2_bit_cnt_t;

    // CPU request, strobes active low
    typedef struct packed {
        io_addr_t addr;
        byte_t    wdata;
        logic     ior_n;
        logic     iow_n;
        logic     aen_n;
    } io_bus_t;

    typedef struct packed {
        logic dma;
        logic timer;
        logic ppi;
        logic dma_page;
    } io_sel_t;

    // Port B bits 7, 6, 1 and 0
    typedef struct packed {
        logic kbd_clear;
        logic kbd_clk_en;
        logic spk_data;
        logic tmr_gate;
    } ppi_ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        RECV,
        HOLD
    } ps2_state_t;

endpackage

/* xt_bus_decode.sv */
/*
 * System-board I/O decode for ports 0x000-0x0FF in 32-byte blocks.
 * Only the PPI block answers reads; the bus keeps the last byte read.
 */
`timescale 1ns/10ps

module xt_bus_decode (
    input  logic            clock,
    input  logic            reset,
    input  xt_pkg::io_bus_t bus_i,
    input  xt_pkg::byte_t   ppi_rdata_i,
    output xt_pkg::io_sel_t sel_o,
    output logic            dma_cs_n_o,
    output logic            dma_page_cs_n_o,
    output xt_pkg::byte_t   data_bus_o,
    output logic            chipset_drive_o
);
    import xt_pkg::*;

    logic       window;
    logic [2:0] block;
    byte_t      held_data;

    // System-board range only, no DMA cycle in progress
    assign window = ~bus_i.aen_n & (bus_i.addr[9:8] == 2'b00);
    assign block  = bus_i.addr[7:5];

    always_comb begin
        sel_o = '0;
        if (window) begin
            sel_o.dma      = (block == BLK_DMA);
            sel_o.timer    = (block == BLK_TIMER);
            sel_o.ppi      = (block == BLK_PPI);
            sel_o.dma_page = (block == BLK_DMA_PAGE);
        end
    end

    // External DMA chips take active-low selects
    assign dma_cs_n_o      = ~sel_o.dma;
    assign dma_page_cs_n_o = ~sel_o.dma_page;

    assign chipset_drive_o = sel_o.ppi & ~bus_i.ior_n;

    // Bus keeper holds the last byte read
    always_ff @(posedge clock) begin
        if (reset) begin
            held_data <= '0;
        end else if (chipset_drive_o) begin
            held_data <= ppi_rdata_i;
        end
    end

    assign data_bus_o = chipset_drive_o ? ppi_rdata_i : held_data;

endmodule

/* xt_ppi_regs.sv */
/*
 * Fixed-direction 8255 ports: A in (keycode), B out, C in.
 * Mode programming is not supported; the control port reads 0xFF.
 */
`timescale 1ns/10ps

module xt_ppi_regs (
    input  logic              clock,
    input  logic              reset,
    input  xt_pkg::io_bus_t   bus_i,
    input  logic              ppi_sel_i,
    input  xt_pkg::byte_t     keycode_i,
    input  xt_pkg::byte_t     port_c_i,
    output xt_pkg::byte_t     port_b_o,
    output xt_pkg::ppi_ctrl_t ctrl_o,
    output xt_pkg::byte_t     rdata_o
);
    import xt_pkg::*;

    logic  wr_port_b;
    byte_t port_b;

    assign wr_port_b = ppi_sel_i & ~bus_i.iow_n & (bus_i.addr[1:0] == PORT_B[1:0]);

    // Port B output latch
    always_ff @(posedge clock) begin
        if (reset) begin
            port_b <= '0;
        end else if (wr_port_b) begin
            port_b <= bus_i.wdata;
        end
    end

    assign port_b_o = port_b;

    // Read byte from address bits 1..0
    always_comb begin
        case (bus_i.addr[1:0])
            PORT_A[1:0]: rdata_o = keycode_i;
            PORT_B[1:0]: rdata_o = port_b;
            PORT_C[1:0]: rdata_o = port_c_i;
            default:     rdata_o = 8'hFF;
        endcase
    end

    // Port B bits that steer the timer, speaker and keyboard
    assign ctrl_o.tmr_gate   = port_b[0];
    assign ctrl_o.spk_data   = port_b[1];
    assign ctrl_o.kbd_clk_en = port_b[6];
    assign ctrl_o.kbd_clear  = port_b[7];

endmodule

/* xt_speaker_timer.sv */
/*
 * 8253 counter 2 in square-wave mode only, clocked by the system clock.
 * Divisor is written low byte then high byte; 0 means 65536, odd values round down.
 */
`timescale 1ns/10ps

module xt_speaker_timer (
    input  logic              clock,
    input  logic              reset,
    input  xt_pkg::io_bus_t   bus_i,
    input  logic              timer_sel_i,
    input  xt_pkg::ppi_ctrl_t ctrl_i,
    output logic              tone_o,
    output logic              speaker_o
);
    import xt_pkg::*;

    logic        wr_active;
    logic        wr_active_q;
    logic        wr_event;
    logic        wr_data;
    logic        wr_ctrl;
    logic        low_next;
    logic        running;
    logic        load_q;
    logic        hold;
    byte_t       div_low;
    tmr_count_t  divisor;
    tmr_count_t  half;
    tmr_count_t  count;
    logic [16:0] period;
    logic        tone;

    // Byte order toggles, so act once per strobe
    assign wr_active = timer_sel_i & ~bus_i.iow_n;
    assign wr_event  = wr_active & ~wr_active_q;
    assign wr_data   = wr_event & (bus_i.addr[1:0] == PORT_TMR2[1:0]);
    assign wr_ctrl   = wr_event & (bus_i.addr[1:0] == PORT_TMR_CTRL[1:0])
                     & (bus_i.wdata[7:6] == TMR_SC_CTR2);

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_active_q <= 1'b0;
            low_next    <= 1'b1;
            running     <= 1'b0;
            load_q      <= 1'b0;
        end else begin
            wr_active_q <= wr_active;
            load_q      <= 1'b0;
            if (wr_ctrl) begin
                // New control word stops the tone until a full divisor arrives
                low_next <= 1'b1;
                running  <= 1'b0;
            end else if (wr_data) begin
                if (low_next) begin
                    low_next <= 1'b0;
                end else begin
                    low_next <= 1'b1;
                    running  <= 1'b1;
                    load_q   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_data & low_next) begin
            div_low <= bus_i.wdata;
        end
        if (wr_data & ~low_next) begin
            divisor <= {bus_i.wdata, div_low};
        end
    end

    assign period = (divisor == '0) ? 17'h1_0000 : {1'b0, divisor};
    assign half   = period[16:1];

    // Stopped, gated off or freshly loaded
    assign hold = ~running | ~ctrl_i.tmr_gate | load_q;

    // Half-period down-counter
    always_ff @(posedge clock) begin
        if (hold || count == 16'd1) begin
            count <= half;
        end else begin
            count <= count - 16'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tone <= 1'b1;
        end else if (hold) begin
            tone <= 1'b1;
        end else if (count == 16'd1) begin
            tone <= ~tone;
        end
    end

    assign tone_o    = tone;
    assign speaker_o = tone & ctrl_i.spk_data;

endmodule

/* xt_ps2_rx.sv */
/*
 * PS/2 keyboard receiver, one scan code at a time.
 * The clock is held low while a code waits for software to clear it.
 * A partial frame is dropped after PS2_IDLE_CYCLES clocks without an edge.
 */
`timescale 1ns/10ps

module xt_ps2_rx (
    input  logic              clock,
    input  logic              reset,
    input  logic              ps2_clock_i,
    input  logic              ps2_data_i,
    input  xt_pkg::ppi_ctrl_t ctrl_i,
    output xt_pkg::byte_t     keycode_o,
    output logic              keyboard_irq_o,
    output logic              ps2_clock_o
);
    import xt_pkg::*;

    logic [2:0]                clk_sync;
    logic [1:0]                data_sync;
    logic                      fall;
    logic                      bit_in;
    logic                      frame_ok;
    logic                      frame_full;
    ps2_state_t                state;
    ps2_bit_cnt_t              bit_cnt;
    ps2_idle_cnt_t             idle_cnt;
    logic [PS2_FRAME_BITS-1:0] frame;
    byte_t                     keycode;

    // Two-flop synchronizers plus one stage for edge detect
    always_ff @(posedge clock) begin
        if (reset) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clock_i};
            data_sync <= {data_sync[0], ps2_data_i};
        end
    end

    assign fall   = clk_sync[2] & ~clk_sync[1];
    assign bit_in = data_sync[1];

    assign frame_full = (bit_cnt == ps2_bit_cnt_t'(PS2_FRAME_BITS));

    // Start 0, odd parity over data and parity bit, stop 1
    assign frame_ok = ~frame[0] & (^frame[9:1]) & frame[10];

    // Bits arrive LSB first
    always_ff @(posedge clock) begin
        if (fall && (state == IDLE || (state == RECV && !frame_full))) begin
            frame <= {bit_in, frame[PS2_FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            idle_cnt <= '0;
            keycode  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fall) begin
                        bit_cnt  <= ps2_bit_cnt_t'(1);
                        idle_cnt <= '0;
                        state    <= RECV;
                    end
                end
                RECV: begin
                    if (frame_full) begin
                        if (frame_ok && !ctrl_i.kbd_clear) begin
                            keycode <= frame[8:1];
                            state   <= HOLD;
                        end else begin
                            state <= IDLE;
                        end
                    end else if (fall) begin
                        bit_cnt  <= bit_cnt + 1'b1;
                        idle_cnt <= '0;
                    end else if (idle_cnt == ps2_idle_cnt_t'(PS2_IDLE_CYCLES - 1)) begin
                        // Keyboard stalled mid-frame
                        state <= IDLE;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                HOLD: begin
                    if (ctrl_i.kbd_clear) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (ctrl_i.kbd_clear) begin
                keycode <= '0;
            end
        end
    end

    assign keycode_o      = keycode;
    assign keyboard_irq_o = (state == HOLD);

    // Inhibit the keyboard while a code is pending or the clock is disabled
    assign ps2_clock_o = ~keyboard_irq_o & ctrl_i.kbd_clk_en;

endmodule

/* xt_peripherals.sv */
/*
 * Keyboard and speaker part of the XT chipset on an ISA-style I/O bus.
 * One clock; no interrupt controller, timer 2 only, no PS/2 transmit.
 */
`timescale 1ns/10ps

module xt_peripherals (
    input  logic             clock,
    input  logic             reset,
    input  xt_pkg::io_addr_t address_i,
    input  xt_pkg::byte_t    data_i,
    input  logic             io_read_n_i,
    input  logic             io_write_n_i,
    input  logic             address_enable_n_i,
    input  xt_pkg::byte_t    port_c_i,
    input  logic             ps2_clock_i,
    input  logic             ps2_data_i,
    output xt_pkg::byte_t    data_bus_o,
    output logic             chipset_drive_o,
    output logic             dma_cs_n_o,
    output logic             dma_page_cs_n_o,
    output xt_pkg::byte_t    port_b_o,
    output logic             speaker_o,
    output logic             tone_o,
    output logic             keyboard_irq_o,
    output logic             ps2_clock_o
);
    import xt_pkg::*;

    io_bus_t   bus;
    io_sel_t   sel;
    ppi_ctrl_t ppi_ctrl;
    byte_t     ppi_rdata;
    byte_t     keycode;

    // CPU request as one value
    assign bus.addr  = address_i;
    assign bus.wdata = data_i;
    assign bus.ior_n = io_read_n_i;
    assign bus.iow_n = io_write_n_i;
    assign bus.aen_n = address_enable_n_i;

    xt_bus_decode xt_bus_decode_inst (
        .clock           (clock),
        .reset           (reset),
        .bus_i           (bus),
        .ppi_rdata_i     (ppi_rdata),
        .sel_o           (sel),
        .dma_cs_n_o      (dma_cs_n_o),
        .dma_page_cs_n_o (dma_page_cs_n_o),
        .data_bus_o      (data_bus_o),
        .chipset_drive_o (chipset_drive_o)
    );

    xt_ppi_regs xt_ppi_regs_inst (
        .clock     (clock),
        .reset     (reset),
        .bus_i     (bus),
        .ppi_sel_i (sel.ppi),
        .keycode_i (keycode),
        .port_c_i  (port_c_i),
        .port_b_o  (port_b_o),
        .ctrl_o    (ppi_ctrl),
        .rdata_o   (ppi_rdata)
    );

    xt_speaker_timer xt_speaker_timer_inst (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (bus),
        .timer_sel_i (sel.timer),
        .ctrl_i      (ppi_ctrl),
        .tone_o      (tone_o),
        .speaker_o   (speaker_o)
    );

    xt_ps2_rx xt_ps2_rx_inst (
        .clock          (clock),
        .reset          (reset),
        .ps2_clock_i    (ps2_clock_i),
        .ps2_data_i     (ps2_data_i),
        .ctrl_i         (ppi_ctrl),
        .keycode_o      (keycode),
        .keyboard_irq_o (keyboard_irq_o),
        .ps2_clock_o    (ps2_clock_o)
    );

endmodule

/* xt_peripherals_assert.sv */
/*
 * Concurrent checks on the XT peripheral top level, bound to every instance.
 * Sampled on the rising clock and idle during reset.
 */
`timescale 1ns/10ps

module xt_peripherals_assert (
    input logic clock_i,
    input logic reset_i,
    input logic keyboard_irq_i,
    input logic kbd_clock_i,
    input logic dma_cs_n_i,
    input logic dma_page_cs_n_i,
    input logic drive_i,
    input logic io_read_n_i
);

    // Pending scan code keeps the keyboard inhibited
    irq_inhibits_clock: assert property (
        @(posedge clock_i) disable iff (reset_i) keyboard_irq_i |-> !kbd_clock_i
    ) else $error("PS/2 clock released while a scan code is pending");

    // Blocks are disjoint
    dma_selects_exclusive: assert property (
        @(posedge clock_i) disable iff (reset_i) !(!dma_cs_n_i && !dma_page_cs_n_i)
    ) else $error("DMA and DMA page selects low together");

    drive_needs_read: assert property (
        @(posedge clock_i) disable iff (reset_i) drive_i |-> !io_read_n_i
    ) else $error("Chipset drives the data bus without a read strobe");

endmodule

bind xt_peripherals xt_peripherals_assert xt_peripherals_assert_inst (
    .clock_i         (clock),
    .reset_i         (reset),
    .keyboard_irq_i  (keyboard_irq_o),
    .kbd_clock_i     (ps2_clock_o),
    .dma_cs_n_i      (dma_cs_n_o),
    .dma_page_cs_n_i (dma_page_cs_n_o),
    .drive_i         (chipset_drive_o),
    .io_read_n_i     (io_read_n_i)
);

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset source. 8 ns period.
 * Reset is high for the first 2 rising edges and drops on a falling edge.
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    // 4 ns half period
    initial begin
        clock_o = 1'b0;
        forever begin
            #4 clock_o = ~clock_o;
        end
    end

    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

/* tb_xt_peripherals.sv */
/*
 * Table-driven testbench for the XT keyboard and speaker block.
 * Inputs change on the falling clock edge; random values use a fixed seed.
 */
`timescale 1ns/10ps

module tb_xt_peripherals;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_SEL, OP_FRAME, OP_IRQ, OP_TONE, OP_GATED} op_t;

    // OP_SEL packs {ior_n, aen_n} in data and {drive, page_cs_n, dma_cs_n} in exp_val
    typedef struct packed {
        op_t        op;
        logic [9:0] addr;
        logic [7:0] data;
        logic [7:0] exp_val;
    } entry_t;

    logic       clock;
    logic       reset;
    logic [9:0] address_i;
    logic [7:0] data_i;
    logic       io_read_n_i;
    logic       io_write_n_i;
    logic       address_enable_n_i;
    logic [7:0] port_c_i;
    logic       ps2_clock_i;
    logic       ps2_data_i;
    logic [7:0] data_bus_o;
    logic       chipset_drive_o;
    logic       dma_cs_n_o;
    logic       dma_page_cs_n_o;
    logic [7:0] port_b_o;
    logic       speaker_o;
    logic       tone_o;
    logic       keyboard_irq_o;
    logic       ps2_clock_o;

    entry_t      table_q[$];
    logic        table_ready = 1'b0;
    int          error_count = 0;
    int          cur_entry = -1;
    logic [31:0] rng_state = 32'd36703;

    tb_clock_gen tb_clock_gen_inst (.clock_o(clock), .reset_o(reset));

    xt_peripherals xt_peripherals_inst (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random_byte(output logic [7:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state[15:8];
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        error_count++;
        $display("ERR %s: got 0x%0h, expected 0x%0h (entry %0d, %0t)",
                 name, got, want, cur_entry, $time);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Entry %0d at %0t: %s", cur_entry, $time, what);
    endtask

    task automatic add_entry(input op_t op, input logic [9:0] addr, input logic [7:0] data,
                             input logic [7:0] exp_val);
        entry_t e;
        e.op      = op;
        e.addr    = addr;
        e.data    = data;
        e.exp_val = exp_val;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [7:0] v;
        // Decode window and chipset drive
        add_entry(OP_SEL, 10'h000, 8'h02, 8'h02);
        add_entry(OP_SEL, 10'h01F, 8'h02, 8'h02);
        add_entry(OP_SEL, 10'h020, 8'h02, 8'h03);
        add_entry(OP_SEL, 10'h080, 8'h02, 8'h01);
        add_entry(OP_SEL, 10'h09F, 8'h02, 8'h01);
        add_entry(OP_SEL, 10'h0A0, 8'h02, 8'h03);
        add_entry(OP_SEL, 10'h000, 8'h03, 8'h03);
        add_entry(OP_SEL, 10'h080, 8'h03, 8'h03);
        add_entry(OP_SEL, 10'h100, 8'h02, 8'h03);
        add_entry(OP_SEL, 10'h29F, 8'h02, 8'h03);
        add_entry(OP_SEL, 10'h060, 8'h00, 8'h07);
        add_entry(OP_SEL, 10'h063, 8'h00, 8'h07);
        add_entry(OP_SEL, 10'h05F, 8'h00, 8'h03);
        add_entry(OP_SEL, 10'h160, 8'h00, 8'h03);
        add_entry(OP_SEL, 10'h080, 8'h00, 8'h01);
        // Port B write and read back, port C pins
        for (int i = 0; i < 4; i++) begin
            next_random_byte(v);
            add_entry(OP_WRITE, 10'h061, v, 8'h00);
            add_entry(OP_READ, 10'h061, 8'h00, v);
        end
        for (int i = 0; i < 3; i++) begin
            next_random_byte(v);
            add_entry(OP_READ, 10'h062, v, v);
        end
        // Keyboard, bad parity first, then two good frames with clears
        add_entry(OP_WRITE, 10'h061, 8'h40, 8'h00);
        add_entry(OP_IRQ, 10'h000, 8'h00, 8'h00);
        add_entry(OP_READ, 10'h060, 8'h00, 8'h00);
        next_random_byte(v);
        add_entry(OP_FRAME, 10'h000, v, 8'h00);
        for (int i = 0; i < 2; i++) begin
            next_random_byte(v);
            add_entry(OP_FRAME, 10'h000, v, 8'h01);
            add_entry(OP_READ, 10'h060, 8'h00, v);
            add_entry(OP_WRITE, 10'h061, 8'hC0, 8'h00);
            add_entry(OP_IRQ, 10'h000, 8'h00, 8'h00);
            add_entry(OP_READ, 10'h060, 8'h00, 8'h00);
            add_entry(OP_WRITE, 10'h061, 8'h40, 8'h00);
        end
        // Speaker with divisor 20
        add_entry(OP_WRITE, 10'h061, 8'h43, 8'h00);
        add_entry(OP_WRITE, 10'h043, 8'hB6, 8'h00);
        add_entry(OP_WRITE, 10'h042, 8'h14, 8'h00);
        add_entry(OP_WRITE, 10'h042, 8'h00, 8'h00);
        add_entry(OP_TONE, 10'h000, 8'h01, 8'd10);
        add_entry(OP_WRITE, 10'h061, 8'h42, 8'h00);
        add_entry(OP_GATED, 10'h000, 8'h01, 8'd100);
        add_entry(OP_WRITE, 10'h061, 8'h41, 8'h00);
        add_entry(OP_TONE, 10'h000, 8'h00, 8'd10);
    endtask

    task automatic bus_write(input logic [9:0] addr, input logic [7:0] data);
        @(negedge clock);
        address_i          = addr;
        data_i             = data;
        address_enable_n_i = 1'b0;
        io_write_n_i       = 1'b0;
        @(negedge clock);
        io_write_n_i       = 1'b1;
        address_enable_n_i = 1'b1;
    endtask

    task automatic bus_check(input entry_t e);
        @(negedge clock);
        address_i          = e.addr;
        address_enable_n_i = (e.op == OP_SEL) ? e.data[0] : 1'b0;
        io_read_n_i        = (e.op == OP_SEL) ? e.data[1] : 1'b0;
        if (e.op == OP_READ) begin
            port_c_i = e.data;
        end
        #2;
        if (e.op == OP_SEL) begin
            if ({chipset_drive_o, dma_page_cs_n_o, dma_cs_n_o} !== e.exp_val[2:0])
                report_mismatch("chipset_drive_o,dma_page_cs_n_o,dma_cs_n_o",
                                {chipset_drive_o, dma_page_cs_n_o, dma_cs_n_o}, e.exp_val[2:0]);
        end else begin
            if (data_bus_o !== e.exp_val)
                report_mismatch("data_bus_o", data_bus_o, e.exp_val);
            if (chipset_drive_o !== 1'b1)
                report_mismatch("chipset_drive_o", chipset_drive_o, 1);
            if (e.addr == 10'h061 && port_b_o !== e.exp_val)
                report_mismatch("port_b_o", port_b_o, e.exp_val);
        end
        @(negedge clock);
        io_read_n_i        = 1'b1;
        address_enable_n_i = 1'b1;
    endtask

    // Start 0, data LSB first, odd parity, stop 1; 20-clock half period
    task automatic send_ps2_frame(input logic [7:0] code, input logic good_parity);
        logic [10:0] bits;
        bits = {1'b1, good_parity ? ~^code : ^code, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data_i = bits[i];
            repeat (10) @(negedge clock);
            ps2_clock_i = 1'b0;
            repeat (20) @(negedge clock);
            ps2_clock_i = 1'b1;
            repeat (10) @(negedge clock);
        end
        ps2_data_i = 1'b1;
    endtask

    task automatic wait_for_irq(input logic level, input int max_cycles, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < max_cycles && !seen; n++) begin
            @(negedge clock);
            seen = (keyboard_irq_o === level);
        end
    endtask

    task automatic measure_tone(input logic spk, input logic [7:0] half);
        int   low_len;
        int   high_len;
        logic prev;
        logic found;
        found = 1'b0;
        prev  = tone_o;
        for (int n = 0; n < 1000 && !found; n++) begin
            @(negedge clock);
            found = prev && !tone_o;
            prev  = tone_o;
        end
        if (!found) begin
            report_failure("tone_o never fell within 1000 clocks");
        end else begin
            low_len  = 0;
            high_len = 0;
            while (tone_o === 1'b0 && low_len < 1000) begin
                if (speaker_o !== 1'b0)
                    report_mismatch("speaker_o", speaker_o, 0);
                low_len++;
                @(negedge clock);
            end
            while (tone_o === 1'b1 && high_len < 1000) begin
                if (speaker_o !== spk)
                    report_mismatch("speaker_o", speaker_o, spk);
                high_len++;
                @(negedge clock);
            end
            if (low_len != half)
                report_mismatch("tone_o low clocks", low_len, half);
            if (high_len != half)
                report_mismatch("tone_o high clocks", high_len, half);
        end
    endtask

    task automatic run_entry(input entry_t e);
        logic seen;
        case (e.op)
            OP_WRITE: bus_write(e.addr, e.data);
            OP_READ, OP_SEL: bus_check(e);
            OP_FRAME: begin
                send_ps2_frame(e.data, e.exp_val[0]);
                wait_for_irq(1'b1, 200, seen);
                if (e.exp_val[0] && !seen) begin
                    report_failure("keyboard_irq_o did not rise after a valid frame");
                end else if (!e.exp_val[0] && seen) begin
                    report_failure("keyboard_irq_o rose after a frame with bad parity");
                end else if (seen && ps2_clock_o !== 1'b0) begin
                    report_mismatch("ps2_clock_o", ps2_clock_o, 0);
                end
            end
            OP_IRQ: begin
                wait_for_irq(e.exp_val[0], 50, seen);
                if (!seen)
                    report_failure("keyboard_irq_o did not reach the expected level");
            end
            OP_TONE: measure_tone(e.data[0], e.exp_val);
            OP_GATED: begin
                for (int n = 0; n < 10 && tone_o !== 1'b1; n++) begin
                    @(negedge clock);
                end
                repeat (e.exp_val) begin
                    @(negedge clock);
                    if (tone_o !== 1'b1)
                        report_mismatch("tone_o", tone_o, 1);
                    if (speaker_o !== e.data[0])
                        report_mismatch("speaker_o", speaker_o, e.data[0]);
                end
            end
            default: report_failure("unknown table operation");
        endcase
    endtask

    initial begin
        address_i          = '0;
        data_i             = '0;
        io_read_n_i        = 1'b1;
        io_write_n_i       = 1'b1;
        address_enable_n_i = 1'b1;
        port_c_i           = '0;
        ps2_clock_i        = 1'b1;
        ps2_data_i         = 1'b1;
        build_table();
        table_ready = 1'b1;
        wait (reset === 1'b0);
        @(negedge clock);
        #2;
        if (port_b_o !== 8'h00) report_mismatch("port_b_o", port_b_o, 0);
        if (speaker_o !== 1'b0) report_mismatch("speaker_o", speaker_o, 0);
        if (keyboard_irq_o !== 1'b0) report_mismatch("keyboard_irq_o", keyboard_irq_o, 0);
        if (ps2_clock_o !== 1'b0) report_mismatch("ps2_clock_o", ps2_clock_o, 0);
        if (dma_cs_n_o !== 1'b1) report_mismatch("dma_cs_n_o", dma_cs_n_o, 1);
        if (dma_page_cs_n_o !== 1'b1) report_mismatch("dma_page_cs_n_o", dma_page_cs_n_o, 1);
        foreach (table_q[i]) begin
            cur_entry = i;
            run_entry(table_q[i]);
        end
        $display("Table entries: %0d, errors: %0d", table_q.size(), error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Invariants sampled just after the rising edge
    initial begin
        wait (reset === 1'b0);
        forever begin
            @(posedge clock);
            #1;
            if (keyboard_irq_o && ps2_clock_o)
                report_failure("PS/2 clock released while a scan code is pending");
            if (!dma_cs_n_o && !dma_page_cs_n_o)
                report_failure("both DMA selects low together");
            if (chipset_drive_o && io_read_n_i)
                report_failure("chipset drives the data bus without a read strobe");
        end
    end

    // 1000 clocks of 8 ns per table entry
    initial begin
        longint limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = longint'(table_q.size()) * 1000 * 8;
        #(limit_ns);
        $display("Timeout: run did not finish within %0d ns", limit_ns);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* vlog.f */
xt_pkg.sv
xt_bus_decode.sv
xt_ppi_regs.sv
xt_speaker_timer.sv
xt_ps2_rx.sv
xt_peripherals.sv
xt_peripherals_assert.sv
tb_clock_gen.sv
tb_xt_peripherals.sv

/* Makefile */
SIM := obj_dir/Vtb_xt_peripherals

.PHONY: all run lint clean

all: run

$(SIM): vlog.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_xt_peripherals -f vlog.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --top-module xt_peripherals xt_pkg.sv xt_bus_decode.sv \
		xt_ppi_regs.sv xt_speaker_timer.sv xt_ps2_rx.sv xt_peripherals.sv

clean:
	rm -rf obj_dir sim.log
